// ==== logic/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

        ////////////////////////////////////////
        // number formats
        ////////////////////////////////////////

        // one half-precision value with sign, 5-bit exponent and 10-bit fraction
        typedef logic [15:0] fp16_t;

        // index of one tap inside the kernel window
        typedef logic [3:0] tap_t;

        localparam fp16_t FP16_ZERO = 16'h0000;

        ////////////////////////////////////////
        // kernel geometry
        ////////////////////////////////////////

        localparam int KERNEL_DIM = 3;

        // taps are numbered row by row, tap 0 at the top left
        localparam int KERNEL_TAPS = KERNEL_DIM * KERNEL_DIM;

endpackage

`default_nettype wire

// ==== logic/fp16_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp16_mac import conv_pkg::*; (
        input  fp16_t a,
        input  fp16_t b,
        input  fp16_t acc,
        output fp16_t sum
);

        localparam int BIAS = 15;
        // both operands are aligned to 20 fraction bits before the add
        localparam int FRAC_W = 20;

        typedef logic signed [7:0] exp_t;
        typedef logic [22:0] mag_t;

        // a zero operand gets this exponent so it never wins the alignment
        localparam exp_t EXP_NONE = -8'sd64;

        logic        a_zero;
        logic        b_zero;
        logic        p_zero;
        logic        c_zero;
        logic [10:0] sig_a;
        logic [10:0] sig_b;
        logic [21:0] p_prod;
        logic        p_sign;
        logic        c_sign;
        exp_t        p_exp;
        exp_t        c_exp;
        mag_t        p_mag;
        mag_t        c_mag;

        // subnormals are flushed, so a zero exponent field means zero
        assign a_zero = (a[14:10] == 5'd0);
        assign b_zero = (b[14:10] == 5'd0);
        assign c_zero = (acc[14:10] == 5'd0);
        assign p_zero = a_zero | b_zero;

        assign sig_a = {1'b1, a[9:0]};
        assign sig_b = {1'b1, b[9:0]};
        assign p_prod = sig_a * sig_b;

        assign p_sign = a[15] ^ b[15];
        assign c_sign = acc[15];

        assign p_exp = p_zero ? EXP_NONE :
                       exp_t'(a[14:10]) + exp_t'(b[14:10]) - exp_t'(BIAS);
        assign c_exp = c_zero ? EXP_NONE : exp_t'(acc[14:10]);

        // the product has its leading one at bit 20 or 21, the accumulator at bit 20
        assign p_mag = p_zero ? '0 : {1'b0, p_prod};
        assign c_mag = c_zero ? '0 : {2'b00, 1'b1, acc[9:0], 10'd0};

        ////////////////////////////////////////
        // align, add and normalize
        ////////////////////////////////////////

        always_comb begin
                exp_t big_exp;
                exp_t small_exp;
                exp_t shift;
                exp_t lead;
                exp_t res_exp;
                mag_t big_mag;
                mag_t small_mag;
                mag_t aligned;
                mag_t total;
                mag_t norm;
                logic big_sign;
                logic small_sign;
                logic res_sign;

                if (p_exp >= c_exp) begin
                        big_exp = p_exp;
                        big_mag = p_mag;
                        big_sign = p_sign;
                        small_exp = c_exp;
                        small_mag = c_mag;
                        small_sign = c_sign;
                end else begin
                        big_exp = c_exp;
                        big_mag = c_mag;
                        big_sign = c_sign;
                        small_exp = p_exp;
                        small_mag = p_mag;
                        small_sign = p_sign;
                end

                shift = big_exp - small_exp;
                aligned = (shift > 8'sd22) ? '0 : (small_mag >> shift);

                if (big_sign == small_sign) begin
                        total = big_mag + aligned;
                        res_sign = big_sign;
                end else if (big_mag >= aligned) begin
                        total = big_mag - aligned;
                        res_sign = big_sign;
                end else begin
                        total = aligned - big_mag;
                        res_sign = small_sign;
                end

                // leading-one search, the highest set bit wins
                lead = '0;
                for (int i = 0; i < 23; i++) begin
                        if (total[i]) begin
                                lead = exp_t'(i);
                        end
                end

                res_exp = big_exp + lead - exp_t'(FRAC_W);
                norm = total << (exp_t'(22) - lead);

                // the fraction is truncated, overflow saturates to the largest finite value
                if (total == '0 || res_exp <= 0) begin
                        sum = FP16_ZERO;
                end else if (res_exp >= 31) begin
                        sum = {res_sign, 15'h7bff};
                end else begin
                        sum = {res_sign, res_exp[4:0], norm[21:12]};
                end
        end

endmodule

`default_nettype wire

// ==== logic/conv_lane_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_lane_array import conv_pkg::*; #(
        parameter int PARA = 4
) (
        input  logic             clk,
        input  logic             rst_n,
        input  logic             lane_clear,
        input  logic             lane_step,
        input  logic             lane_finish,
        input  logic             lane_relu,
        input  fp16_t            lane_weight,
        input  fp16_t [PARA-1:0] lane_pixels,
        output fp16_t [PARA-1:0] lane_sums
);

        fp16_t [PARA-1:0] acc_q;
        fp16_t [PARA-1:0] mac_sum;
        fp16_t [PARA-1:0] sums_q;

        // every lane sees the same weight and its own pixel
        for (genvar i = 0; i < PARA; i++) begin : g_lane
                fp16_mac u_mac (
                        .a   (lane_pixels[i]),
                        .b   (lane_weight),
                        .acc (acc_q[i]),
                        .sum (mac_sum[i])
                );
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        acc_q <= {PARA{FP16_ZERO}};
                end else if (lane_clear) begin
                        acc_q <= {PARA{FP16_ZERO}};
                end else if (lane_step) begin
                        acc_q <= mac_sum;
                end
        end

        // result register, a set sign bit means the sum is negative
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        sums_q <= {PARA{FP16_ZERO}};
                end else if (lane_finish) begin
                        for (int i = 0; i < PARA; i++) begin
                                if (lane_relu && acc_q[i][15]) begin
                                        sums_q[i] <= FP16_ZERO;
                                end else begin
                                        sums_q[i] <= acc_q[i];
                                end
                        end
                end
        end

        assign lane_sums = sums_q;

endmodule

`default_nettype wire

// ==== logic/feature_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module feature_mem import conv_pkg::*; #(
        parameter int PARA = 4,
        parameter int ROW_ADDR_W = 3
) (
        input  logic                  clk,
        input  logic                  en,
        input  logic                  we,
        input  logic [ROW_ADDR_W-1:0] addr,
        input  fp16_t [PARA+1:0]      wdata,
        output fp16_t [PARA+1:0]      rdata
);

        localparam int ROWS = 2 ** ROW_ADDR_W;

        fp16_t [PARA+1:0] mem [ROWS];

        // read data only changes on a read, so it holds through later writes
        always_ff @(posedge clk) begin
                if (en) begin
                        if (we) begin
                                mem[addr] <= wdata;
                        end else begin
                                rdata <= mem[addr];
                        end
                end
        end

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import conv_pkg::*; #(
        parameter int PARA = 4,
        parameter int ROW_ADDR_W = 3
) (
        input  logic                  rd_req,
        input  logic [ROW_ADDR_W-1:0] rd_addr,
        input  logic                  load_valid,
        input  logic [ROW_ADDR_W-1:0] load_addr,
        input  fp16_t [PARA+1:0]      load_row,
        output logic                  load_ready,
        output logic                  mem_en,
        output logic                  mem_we,
        output logic [ROW_ADDR_W-1:0] mem_addr,
        output fp16_t [PARA+1:0]      mem_wdata
);

        logic rd_gnt;
        logic ld_gnt;

        // the sequencer is requester 1 and always wins
        assign rd_gnt = rd_req;

        // host load port is requester 0 and only gets the idle cycles
        assign load_ready = ~rd_req;
        assign ld_gnt = load_valid & load_ready;

        assign mem_en = rd_gnt | ld_gnt;
        assign mem_we = ld_gnt;
        assign mem_addr = rd_gnt ? rd_addr : load_addr;
        assign mem_wdata = load_row;

endmodule

`default_nettype wire

// ==== logic/conv_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_sequencer import conv_pkg::*; #(
        parameter int PARA = 4,
        parameter int ROW_ADDR_W = 3
) (
        input  logic                        clk,
        input  logic                        rst_n,
        input  logic                        cmd_valid,
        input  logic [ROW_ADDR_W-1:0]       cmd_row,
        input  fp16_t [KERNEL_TAPS-1:0]     cmd_weights,
        input  logic                        cmd_relu,
        output logic                        cmd_ready,
        output logic                        rd_req,
        output logic [ROW_ADDR_W-1:0]       rd_addr,
        input  fp16_t [PARA+KERNEL_DIM-2:0] rd_row,
        output logic                        lane_clear,
        output logic                        lane_step,
        output logic                        lane_finish,
        output logic                        lane_relu,
        output fp16_t                       lane_weight,
        output fp16_t [PARA-1:0]            lane_pixels,
        input  logic                        res_ready,
        output logic                        res_valid
);

        typedef enum logic [2:0] {
                IDLE,
                CLEAR,
                READ,
                STEP,
                FINISH,
                HOLD
        } seq_state_t;

        seq_state_t state;
        seq_state_t state_nxt;

        tap_t       tap;
        logic [1:0] kx;
        logic [1:0] ky;
        logic       last_tap;

        logic [ROW_ADDR_W-1:0]   row_q;
        fp16_t [KERNEL_TAPS-1:0] weights_q;
        logic                    relu_q;

        assign last_tap = (tap == tap_t'(KERNEL_TAPS - 1));

        ////////////////////////////////////////
        // state machine
        ////////////////////////////////////////

        // clear, then per kernel row one read and three steps, then finish
        always_comb begin
                state_nxt = state;
                case (state)
                        IDLE:   if (cmd_valid) state_nxt = CLEAR;
                        CLEAR:  state_nxt = READ;
                        READ:   state_nxt = STEP;
                        STEP: begin
                                if (last_tap) begin
                                        state_nxt = FINISH;
                                end else if (kx == 2'(KERNEL_DIM - 1)) begin
                                        state_nxt = READ;
                                end
                        end
                        FINISH: state_nxt = HOLD;
                        HOLD:   if (res_ready) state_nxt = IDLE;
                        default: state_nxt = IDLE;
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= IDLE;
                        tap <= '0;
                        kx <= '0;
                        ky <= '0;
                end else begin
                        state <= state_nxt;
                        if (state == CLEAR) begin
                                tap <= '0;
                                kx <= '0;
                                ky <= '0;
                        end else if (state == STEP && !last_tap) begin
                                tap <= tap + 1'b1;
                                if (kx == 2'(KERNEL_DIM - 1)) begin
                                        kx <= '0;
                                        ky <= ky + 1'b1;
                                end else begin
                                        kx <= kx + 1'b1;
                                end
                        end
                end
        end

        // command is held for the whole run
        always_ff @(posedge clk) begin
                if (state == IDLE && cmd_valid) begin
                        row_q <= cmd_row;
                        weights_q <= cmd_weights;
                        relu_q <= cmd_relu;
                end
        end

        ////////////////////////////////////////
        // outputs
        ////////////////////////////////////////

        assign cmd_ready = (state == IDLE);
        assign res_valid = (state == HOLD);

        // row addresses wrap around the top of the memory
        assign rd_req = (state == READ);
        assign rd_addr = row_q + ROW_ADDR_W'(ky);

        assign lane_clear = (state == CLEAR);
        assign lane_step = (state == STEP);
        assign lane_finish = (state == FINISH);
        assign lane_relu = relu_q;

        // the row slice at offset kx lines each lane up with its window column
        assign lane_weight = weights_q[tap];
        assign lane_pixels = rd_row[kx +: PARA];

endmodule

`default_nettype wire

// ==== logic/conv_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_top import conv_pkg::*; #(
        parameter int PARA = 4,
        parameter int ROW_ADDR_W = 3
) (
        input  logic                        clk,
        input  logic                        rst_n,
        input  logic                        load_valid,
        output logic                        load_ready,
        input  logic [ROW_ADDR_W-1:0]       load_addr,
        input  fp16_t [PARA+KERNEL_DIM-2:0] load_row,
        input  logic                        cmd_valid,
        output logic                        cmd_ready,
        input  logic [ROW_ADDR_W-1:0]       cmd_row,
        input  fp16_t [KERNEL_TAPS-1:0]     cmd_weights,
        input  logic                        cmd_relu,
        output logic                        res_valid,
        input  logic                        res_ready,
        output fp16_t [PARA-1:0]            res_data
);

        logic                        rd_req;
        logic [ROW_ADDR_W-1:0]       rd_addr;
        fp16_t [PARA+KERNEL_DIM-2:0] rd_row;
        logic                        mem_en;
        logic                        mem_we;
        logic [ROW_ADDR_W-1:0]       mem_addr;
        fp16_t [PARA+KERNEL_DIM-2:0] mem_wdata;
        logic                        lane_clear;
        logic                        lane_step;
        logic                        lane_finish;
        logic                        lane_relu;
        fp16_t                       lane_weight;
        fp16_t [PARA-1:0]            lane_pixels;

        conv_sequencer #(
                .PARA       (PARA),
                .ROW_ADDR_W (ROW_ADDR_W)
        ) u_seq (
                .clk         (clk),
                .rst_n       (rst_n),
                .cmd_valid   (cmd_valid),
                .cmd_row     (cmd_row),
                .cmd_weights (cmd_weights),
                .cmd_relu    (cmd_relu),
                .cmd_ready   (cmd_ready),
                .rd_req      (rd_req),
                .rd_addr     (rd_addr),
                .rd_row      (rd_row),
                .lane_clear  (lane_clear),
                .lane_step   (lane_step),
                .lane_finish (lane_finish),
                .lane_relu   (lane_relu),
                .lane_weight (lane_weight),
                .lane_pixels (lane_pixels),
                .res_ready   (res_ready),
                .res_valid   (res_valid)
        );

        // result register of the lanes is the output stream payload
        conv_lane_array #(
                .PARA (PARA)
        ) u_lanes (
                .clk         (clk),
                .rst_n       (rst_n),
                .lane_clear  (lane_clear),
                .lane_step   (lane_step),
                .lane_finish (lane_finish),
                .lane_relu   (lane_relu),
                .lane_weight (lane_weight),
                .lane_pixels (lane_pixels),
                .lane_sums   (res_data)
        );

        mem_arbiter #(
                .PARA       (PARA),
                .ROW_ADDR_W (ROW_ADDR_W)
        ) u_arb (
                .rd_req     (rd_req),
                .rd_addr    (rd_addr),
                .load_valid (load_valid),
                .load_addr  (load_addr),
                .load_row   (load_row),
                .load_ready (load_ready),
                .mem_en     (mem_en),
                .mem_we     (mem_we),
                .mem_addr   (mem_addr),
                .mem_wdata  (mem_wdata)
        );

        feature_mem #(
                .PARA       (PARA),
                .ROW_ADDR_W (ROW_ADDR_W)
        ) u_mem (
                .clk   (clk),
                .en    (mem_en),
                .we    (mem_we),
                .addr  (mem_addr),
                .wdata (mem_wdata),
                .rdata (rd_row)
        );

endmodule

`default_nettype wire

// ==== test/conv_top_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_top_props import conv_pkg::*; #(
        parameter int PARA = 4
) (
        input logic             clk,
        input logic             rst_n,
        input logic             cmd_ready,
        input logic             res_valid,
        input logic             res_ready,
        input logic             load_ready,
        input logic             rd_req,
        input fp16_t [PARA-1:0] res_data
);

        // read by the testbench at the end of the run
        int fail_count = 0;

        // a stalled result keeps both its valid and its payload
        hold_result: assert property (@(posedge clk) disable iff (!rst_n)
                res_valid && !res_ready |=> res_valid && $stable(res_data))
        else begin
                $error("res_data or res_valid changed while res_ready was low");
                fail_count++;
        end

        // a row read holds the host port off for a single cycle only
        host_wait_bounded: assert property (@(posedge clk) disable iff (!rst_n)
                rd_req |=> load_ready)
        else begin
                $error("load_ready stayed low for more than one cycle after a row read");
                fail_count++;
        end

        // cmd_ready can only come back once the pending result has transferred
        one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
                !cmd_ready && !(res_valid && res_ready) |=> !cmd_ready)
        else begin
                $error("cmd_ready rose before the result transferred");
                fail_count++;
        end

endmodule

`default_nettype wire

// ==== test/conv_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_top_tb import conv_pkg::*; ();

        localparam int PARA = 4;
        localparam int ROW_ADDR_W = 3;
        localparam int ROWS = 2 ** ROW_ADDR_W;
        localparam int ROW_W = PARA + KERNEL_DIM - 1;
        localparam int CLK_HALF = 2;
        localparam int RESET_CYCLES = 10;
        localparam int LATENCY = 15;
        localparam int TIMEOUT = 40;
        localparam int NUM_TESTS = 16;

        ////////////////////////////////////////
        // test table
        ////////////////////////////////////////

        // row 6 wraps the window around the top of the memory
        localparam int TBL_ROW [NUM_TESTS] = '{0, 1, 2, 3, 4, 5, 0, 1, 2, 3, 4, 5, 2, 6, 0, 5};
        localparam int TBL_RELU [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 0, 1, 0, 0};
        localparam int TBL_DELAY [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3, 6, 0, 1};
        // test 14 rewrites the last row mid command, test 15 reads it back
        localparam int TBL_LOAD [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0};

        logic                        clk;
        logic                        rst_n;
        logic                        load_valid;
        logic                        load_ready;
        logic [ROW_ADDR_W-1:0]       load_addr;
        fp16_t [ROW_W-1:0]           load_row;
        logic                        cmd_valid;
        logic                        cmd_ready;
        logic [ROW_ADDR_W-1:0]       cmd_row;
        fp16_t [KERNEL_TAPS-1:0]     cmd_weights;
        logic                        cmd_relu;
        logic                        res_valid;
        logic                        res_ready;
        fp16_t [PARA-1:0]            res_data;

        int          pix [ROWS][ROW_W];
        int          wgt [KERNEL_TAPS];
        fp16_t       expected [PARA];
        logic [31:0] lfsr_q;
        int          test_errs;
        int          tests_run;
        int          tests_failed;
        int          errors_total;

        conv_top #(
                .PARA       (PARA),
                .ROW_ADDR_W (ROW_ADDR_W)
        ) UUT (
                .clk         (clk),
                .rst_n       (rst_n),
                .load_valid  (load_valid),
                .load_ready  (load_ready),
                .load_addr   (load_addr),
                .load_row    (load_row),
                .cmd_valid   (cmd_valid),
                .cmd_ready   (cmd_ready),
                .cmd_row     (cmd_row),
                .cmd_weights (cmd_weights),
                .cmd_relu    (cmd_relu),
                .res_valid   (res_valid),
                .res_ready   (res_ready),
                .res_data    (res_data)
        );

        bind conv_top conv_top_props #(
                .PARA (PARA)
        ) u_props (
                .clk        (clk),
                .rst_n      (rst_n),
                .cmd_ready  (cmd_ready),
                .res_valid  (res_valid),
                .res_ready  (res_ready),
                .load_ready (load_ready),
                .rd_req     (rd_req),
                .res_data   (res_data)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #CLK_HALF clk = ~clk;
                end
        end

        ////////////////////////////////////////
        // stimulus and reference model
        ////////////////////////////////////////

        // x^32 + x^22 + x^2 + x + 1, new bit shifted in at the bottom
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic int take_bits(input int n);
                int v;
                v = 0;
                for (int i = 0; i < n; i++) begin
                        lfsr_q = lfsr_next(lfsr_q);
                        v = (v << 1) | int'(lfsr_q[0]);
                end
                return v;
        endfunction

        // exact for magnitudes below 2048, which covers every value used here
        function automatic fp16_t int_to_fp16(input int v);
                int    mag;
                int    lead;
                fp16_t r;
                mag = (v < 0) ? -v : v;
                lead = 0;
                for (int i = 0; i < 11; i++) begin
                        if (((mag >> i) & 1) == 1) begin
                                lead = i;
                        end
                end
                if (mag == 0) begin
                        r = FP16_ZERO;
                end else begin
                        r[15] = (v < 0);
                        r[14:10] = 5'(lead + 15);
                        r[9:0] = 10'((mag << (10 - lead)) & 'h3ff);
                end
                return r;
        endfunction

        // lane i sees pixels i to i+2 of each of the three rows
        function automatic void compute_expected(input int row, input logic relu);
                int acc;
                int r;
                for (int i = 0; i < PARA; i++) begin
                        acc = 0;
                        for (int ky = 0; ky < KERNEL_DIM; ky++) begin
                                r = (row + ky) % ROWS;
                                for (int kx = 0; kx < KERNEL_DIM; kx++) begin
                                        acc += pix[r][i + kx] * wgt[ky * KERNEL_DIM + kx];
                                end
                        end
                        if (relu && acc < 0) begin
                                acc = 0;
                        end
                        expected[i] = int_to_fp16(acc);
                end
        endfunction

        ////////////////////////////////////////
        // checks and bus tasks
        ////////////////////////////////////////

        task automatic abort_run(input string why);
                $display("timeout: %s", why);
                $display("RESULT: FAIL");
                $finish;
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        $display("error: %s is %0h, expected %0h", name, got, exp);
                        test_errs++;
                end
        endtask

        task automatic check_data();
                for (int i = 0; i < PARA; i++) begin
                        check_value($sformatf("res_data[%0d]", i), res_data[i], expected[i]);
                end
        endtask

        task automatic finish_test(input string name);
                tests_run++;
                if (test_errs != 0) begin
                        tests_failed++;
                        errors_total += test_errs;
                end
                $display("%s: %s", name, (test_errs == 0) ? "ok" : "failed");
        endtask

        // writes pix[addr] through the host port, entered on a falling edge
        task automatic write_row(input int addr, output int stalls);
                int waited;
                load_addr = ROW_ADDR_W'(addr);
                for (int i = 0; i < ROW_W; i++) begin
                        load_row[i] = int_to_fp16(pix[addr][i]);
                end
                load_valid = 1'b1;
                waited = 0;
                while (!load_ready) begin
                        if (waited == TIMEOUT) begin
                                abort_run("load_ready stayed low for a host load");
                        end
                        @(negedge clk);
                        waited++;
                end
                stalls = waited;
                @(posedge clk);
                @(negedge clk);
                load_valid = 1'b0;
        endtask

        task automatic run_test(input int t);
                int waited;
                int edges;
                int stalls;
                test_errs = 0;
                stalls = 0;
                edges = 0;
                for (int k = 0; k < KERNEL_TAPS; k++) begin
                        // relu runs lean towards -1 so that some lanes end up negative
                        if (TBL_RELU[t] != 0 && take_bits(1) == 1) begin
                                wgt[k] = -1;
                        end else begin
                                wgt[k] = take_bits(3) % 5 - 1;
                        end
                        cmd_weights[k] = int_to_fp16(wgt[k]);
                end
                compute_expected(TBL_ROW[t], TBL_RELU[t] != 0);
                waited = 0;
                while (!cmd_ready) begin
                        if (waited == TIMEOUT) begin
                                abort_run("cmd_ready stayed low before a command");
                        end
                        @(negedge clk);
                        waited++;
                end
                cmd_row = ROW_ADDR_W'(TBL_ROW[t]);
                cmd_relu = (TBL_RELU[t] != 0);
                cmd_valid = 1'b1;
                @(posedge clk);
                fork
                        begin
                                // the accepting edge counts as the first cycle
                                @(negedge clk);
                                cmd_valid = 1'b0;
                                edges = 1;
                                while (!res_valid) begin
                                        if (edges > LATENCY + TIMEOUT) begin
                                                abort_run("res_valid never rose after a command");
                                        end
                                        @(negedge clk);
                                        edges++;
                                end
                        end
                        begin
                                if (TBL_LOAD[t] != 0) begin
                                        // the second falling edge lands in the first row read
                                        @(negedge clk);
                                        @(negedge clk);
                                        for (int i = 0; i < ROW_W; i++) begin
                                                pix[ROWS-1][i] = take_bits(3) % 5;
                                        end
                                        write_row(ROWS - 1, stalls);
                                end
                        end
                join
                if (edges != LATENCY) begin
                        $display("res_valid rose %0d cycles after the command, not %0d",
                                 edges, LATENCY);
                        test_errs++;
                end
                if (TBL_LOAD[t] != 0 && stalls == 0) begin
                        $display("host load during a row read was not held off");
                        test_errs++;
                end
                for (int d = 0; d < TBL_DELAY[t]; d++) begin
                        check_data();
                        check_value("res_valid", res_valid, 1);
                        check_value("cmd_ready", cmd_ready, 0);
                        @(negedge clk);
                end
                check_data();
                check_value("res_valid", res_valid, 1);
                res_ready = 1'b1;
                @(posedge clk);
                @(negedge clk);
                res_ready = 1'b0;
                check_value("res_valid", res_valid, 0);
                check_value("cmd_ready", cmd_ready, 1);
        endtask

        ////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////

        initial begin
                int stalls;
                rst_n = 1'b0;
                load_valid = 1'b0;
                load_addr = '0;
                load_row = '0;
                cmd_valid = 1'b0;
                cmd_row = '0;
                cmd_weights = '0;
                cmd_relu = 1'b0;
                res_ready = 1'b0;
                lfsr_q = 32'h2582d578;
                tests_run = 0;
                tests_failed = 0;
                errors_total = 0;
                repeat (RESET_CYCLES) @(negedge clk);
                rst_n = 1'b1;

                test_errs = 0;
                check_value("cmd_ready", cmd_ready, 1);
                check_value("load_ready", load_ready, 1);
                check_value("res_valid", res_valid, 0);
                check_value("rd_req", UUT.rd_req, 0);
                finish_test("reset state");

                // pixels come from {0, 1, 2, 3, 4}
                for (int r = 0; r < ROWS; r++) begin
                        for (int i = 0; i < ROW_W; i++) begin
                                pix[r][i] = take_bits(3) % 5;
                        end
                        write_row(r, stalls);
                end

                for (int t = 0; t < NUM_TESTS; t++) begin
                        run_test(t);
                        finish_test($sformatf("test %0d row %0d relu %0d delay %0d load %0d",
                                              t, TBL_ROW[t], TBL_RELU[t], TBL_DELAY[t],
                                              TBL_LOAD[t]));
                end

                $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                         tests_run, tests_failed, errors_total, UUT.u_props.fail_count);
                if (tests_failed == 0 && UUT.u_props.fail_count == 0) begin
                        $display("RESULT: PASS");
                end else begin
                        $display("RESULT: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== build.f ====
logic/conv_pkg.sv
logic/fp16_mac.sv
logic/conv_lane_array.sv
logic/feature_mem.sv
logic/mem_arbiter.sv
logic/conv_sequencer.sv
logic/conv_top.sv
test/conv_top_props.sv
test/conv_top_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module conv_top_tb \
        -f build.f -o conv_sim || { echo "build failed"; exit 1; }
./obj_dir/conv_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
        && echo "simulation passed" \
        || { echo "simulation failed"; exit 1; }
